/* design/alu.sv */
`timescale 1ns/1ps

module alu (
	input logic [mipsPkg::dataW-1:0] a,
	input logic [mipsPkg::dataW-1:0] b,
	input mipsPkg::aluCtrlT aluControl,
	output logic [mipsPkg::dataW-1:0] result,
	output logic zero
);
	import mipsPkg::*;

	// Signed compare for slt
	logic lessThan;

	assign lessThan = $signed(a) < $signed(b);

	always_comb begin
		case (aluControl)
			aluAnd: result = a & b;
			aluOr: result = a | b;
			aluAdd: result = a + b;
			aluSub: result = a - b;
			aluSlt: result = {{(dataW-1){1'b0}}, lessThan};
			aluNor: result = ~(a | b);
			default: result = '0;
		endcase
	end

	// Branch decision input
	assign zero = (result == '0);

endmodule

/* design/aluDecoder.sv */
`timescale 1ns/1ps

module aluDecoder (
	input mipsPkg::aluOpT aluOp,
	input mipsPkg::functT funct,
	input mipsPkg::opcodeT opcode,
	output mipsPkg::aluCtrlT aluControl
);
	import mipsPkg::*;

	always_comb begin
		case (aluOp)
			// Address and PC arithmetic
			aluOpAdd: aluControl = aluAdd;
			// Branch compare
			aluOpSub: aluControl = aluSub;
			// R-type, decode funct
			aluOpFunct: begin
				case (funct)
					fnAdd: aluControl = aluAdd;
					fnSub: aluControl = aluSub;
					fnAnd: aluControl = aluAnd;
					fnOr: aluControl = aluOr;
					fnSlt: aluControl = aluSlt;
					// Unknown funct falls back to add
					default: aluControl = aluAdd;
				endcase
			end
			// I-type, decode opcode
			default: begin
				case (opcode)
					opAndi: aluControl = aluAnd;
					opOri: aluControl = aluOr;
					opSlti: aluControl = aluSlt;
					// addi and anything else
					default: aluControl = aluAdd;
				endcase
			end
		endcase
	end

endmodule

/* design/controlUnit.sv */
`timescale 1ns/1ps

module controlUnit (
	input logic cclk,
	input logic rstb,
	input logic ack,
	output logic cyc,
	output logic stb,
	output logic we,
	ctrlIf.ctrl ctl
);
	import mipsPkg::*;

	stateT state, nextState;
	aluOpT aluOp;
	// Current state owns the bus
	logic busState;
	// Blocks strobe for one cycle after any ack
	logic holdOff;

	aluDecoder i_aluDecoder (
		.aluOp(aluOp),
		.funct(ctl.funct),
		.opcode(ctl.opcode),
		.aluControl(ctl.aluControl)
	);

	// Logical immediates are zero extended
	assign ctl.extOp = !(ctl.opcode == opAndi || ctl.opcode == opOri);

	// Strobe drops the cycle after ack
	assign stb = busState & ~holdOff;
	assign cyc = stb;

	always_ff @(posedge cclk) begin
		if (!rstb) begin
			state <= sFetch;
			holdOff <= 1'b1;
		end else begin
			state <= nextState;
			holdOff <= ack;
		end
	end

	always_comb begin
		// Defaults compute PC + 4 with nothing written
		ctl.memtoReg = 1'b0;
		ctl.iorD = 1'b0;
		ctl.regDst = 1'b0;
		ctl.pcSrc = 2'b00;
		ctl.aluSrcA = 1'b0;
		ctl.aluSrcB = 2'b01;
		ctl.branch = 2'b00;
		ctl.irWrite = 1'b0;
		ctl.pcWrite = 1'b0;
		ctl.regWrite = 1'b0;
		ctl.mdrWrite = 1'b0;
		aluOp = aluOpAdd;
		busState = 1'b0;
		we = 1'b0;
		nextState = state;
		case (state)
			sFetch: begin
				// Instruction read, IR and PC load on ack
				busState = 1'b1;
				ctl.irWrite = ack;
				ctl.pcWrite = ack;
				if (ack) begin
					nextState = sDecode;
				end
			end
			sDecode: begin
				// Branch target into ALUOut
				ctl.aluSrcB = 2'b11;
				case (ctl.opcode)
					opRType: nextState = sExecute;
					opLw, opSw: nextState = sMemAdr;
					opBeq, opBne: nextState = sBranch;
					opAddi, opSlti, opAndi, opOri: nextState = sItypeExecute;
					opJ: nextState = sJump;
					// Unsupported opcode acts as a nop
					default: nextState = sFetch;
				endcase
			end
			sMemAdr: begin
				// Base plus offset
				ctl.aluSrcA = 1'b1;
				ctl.aluSrcB = 2'b10;
				nextState = (ctl.opcode == opLw) ? sMemRead : sMemWrite;
			end
			sMemRead: begin
				// Same ALU inputs keep ALUOut and adr stable
				ctl.aluSrcA = 1'b1;
				ctl.aluSrcB = 2'b10;
				ctl.iorD = 1'b1;
				busState = 1'b1;
				ctl.mdrWrite = ack;
				if (ack) begin
					nextState = sMemWriteback;
				end
			end
			sMemWriteback: begin
				// MDR into rt
				ctl.memtoReg = 1'b1;
				ctl.regWrite = 1'b1;
				nextState = sFetch;
			end
			sMemWrite: begin
				// Hold address, B drives write data
				ctl.aluSrcA = 1'b1;
				ctl.aluSrcB = 2'b10;
				ctl.iorD = 1'b1;
				busState = 1'b1;
				we = 1'b1;
				if (ack) begin
					nextState = sFetch;
				end
			end
			sExecute: begin
				ctl.aluSrcA = 1'b1;
				ctl.aluSrcB = 2'b00;
				aluOp = aluOpFunct;
				nextState = sAluWriteback;
			end
			sAluWriteback: begin
				// ALUOut into rd
				ctl.regDst = 1'b1;
				ctl.regWrite = 1'b1;
				nextState = sFetch;
			end
			sBranch: begin
				// Compare A and B, target waits in ALUOut
				ctl.aluSrcA = 1'b1;
				ctl.aluSrcB = 2'b00;
				aluOp = aluOpSub;
				ctl.pcSrc = 2'b01;
				ctl.branch = (ctl.opcode == opBne) ? 2'b10 : 2'b01;
				nextState = sFetch;
			end
			sItypeExecute: begin
				ctl.aluSrcA = 1'b1;
				ctl.aluSrcB = 2'b10;
				aluOp = aluOpItype;
				nextState = sItypeWriteback;
			end
			sItypeWriteback: begin
				// ALUOut into rt
				ctl.regWrite = 1'b1;
				nextState = sFetch;
			end
			sJump: begin
				ctl.pcSrc = 2'b10;
				ctl.pcWrite = 1'b1;
				nextState = sFetch;
			end
			default: begin
				nextState = sFetch;
			end
		endcase
	end

endmodule

/* design/ctrlIf.sv */
`timescale 1ns/1ps

interface ctrlIf;
	import mipsPkg::*;

	// Mux selects
	logic memtoReg, iorD, regDst, aluSrcA;
	logic [1:0] pcSrc, aluSrcB;
	// MSB bne, LSB beq
	logic [1:0] branch;
	// Register enables
	logic irWrite, pcWrite, regWrite, mdrWrite;
	// Zero extend when low
	logic extOp;
	aluCtrlT aluControl;
	// Decoded instruction fields from the IR
	opcodeT opcode;
	functT funct;

	modport ctrl (
		output memtoReg, iorD, regDst, pcSrc, aluSrcA, aluSrcB, branch,
		output irWrite, pcWrite, regWrite, mdrWrite, extOp, aluControl,
		input opcode, funct
	);

	modport dp (
		input memtoReg, iorD, regDst, pcSrc, aluSrcA, aluSrcB, branch,
		input irWrite, pcWrite, regWrite, mdrWrite, extOp, aluControl,
		output opcode, funct
	);

endinterface

/* design/datapath.sv */
`timescale 1ns/1ps

module datapath (
	input logic cclk,
	input logic rstb,
	ctrlIf.dp ctl,
	output logic [mipsPkg::dataW-1:0] adr,
	output logic [mipsPkg::dataW-1:0] datW,
	input logic [mipsPkg::dataW-1:0] datR
);
	import mipsPkg::*;

	// Architectural and holding registers
	logic [dataW-1:0] pc, ir, mdr, aReg, bReg, aluOut;
	// Register file ports
	logic [regAddrW-1:0] wa;
	logic [dataW-1:0] wd, rd1, rd2;
	// ALU operands and result
	logic [dataW-1:0] srcA, srcB, aluResult;
	logic zero;
	// Immediates and next PC
	logic [dataW-1:0] immExt, jumpTarget, pcNext;
	logic pcEn;

	// Fields back to the FSM
	assign ctl.opcode = opcodeT'(ir[dataW-1 -: fieldW]);
	assign ctl.funct = functT'(ir[fieldW-1:0]);

	// Sign bit masked by extOp for andi and ori
	assign immExt = {{(dataW-immW){ir[immW-1] & ctl.extOp}}, ir[immW-1:0]};
	// Upper PC bits with the word index
	assign jumpTarget = {pc[dataW-1 -: 4], ir[25:0], 2'b00};

	// Write register and data
	assign wa = ctl.regDst ? ir[15:11] : ir[20:16];
	assign wd = ctl.memtoReg ? mdr : aluOut;

	regFile i_regFile (
		.cclk(cclk),
		.we(ctl.regWrite),
		.ra1(ir[25:21]),
		.ra2(ir[20:16]),
		.wa(wa),
		.wd(wd),
		.rd1(rd1),
		.rd2(rd2)
	);

	// ALU source muxes
	assign srcA = ctl.aluSrcA ? aReg : pc;
	always_comb begin
		case (ctl.aluSrcB)
			2'b00: srcB = bReg;
			2'b01: srcB = dataW'(4);
			2'b10: srcB = immExt;
			default: srcB = {immExt[dataW-3:0], 2'b00};
		endcase
	end

	alu i_alu (
		.a(srcA),
		.b(srcB),
		.aluControl(ctl.aluControl),
		.result(aluResult),
		.zero(zero)
	);

	// beq on zero, bne on nonzero
	assign pcEn = ctl.pcWrite | (ctl.branch[0] & zero) | (ctl.branch[1] & ~zero);

	always_comb begin
		case (ctl.pcSrc)
			2'b01: pcNext = aluOut;
			2'b10: pcNext = jumpTarget;
			default: pcNext = aluResult;
		endcase
	end

	always_ff @(posedge cclk) begin
		if (!rstb) begin
			pc <= '0;
		end else if (pcEn) begin
			pc <= pcNext;
		end
	end

	// IR and MDR load on their enables
	always_ff @(posedge cclk) begin
		if (ctl.irWrite) begin
			ir <= datR;
		end
		if (ctl.mdrWrite) begin
			mdr <= datR;
		end
	end

	// Operand and result holding registers
	always_ff @(posedge cclk) begin
		aReg <= rd1;
		bReg <= rd2;
		aluOut <= aluResult;
	end

	// Bus side
	assign adr = ctl.iorD ? aluOut : pc;
	assign datW = bReg;

endmodule

/* design/mipsCore.sv */
`timescale 1ns/1ps

module mipsCore (
	input logic cclk,
	input logic rstb,
	// Wishbone classic master
	output logic cyc,
	output logic stb,
	output logic we,
	output logic [mipsPkg::dataW-1:0] adr,
	output logic [mipsPkg::dataW-1:0] datW,
	input logic [mipsPkg::dataW-1:0] datR,
	input logic ack
);

	// Control and decoded fields between FSM and datapath
	ctrlIf ctl ();

	// FSM owns the bus handshake
	controlUnit i_controlUnit (
		.cclk(cclk),
		.rstb(rstb),
		.ack(ack),
		.cyc(cyc),
		.stb(stb),
		.we(we),
		.ctl(ctl.ctrl)
	);

	// Datapath owns address and data
	datapath i_datapath (
		.cclk(cclk),
		.rstb(rstb),
		.ctl(ctl.dp),
		.adr(adr),
		.datW(datW),
		.datR(datR)
	);

endmodule

/* design/mipsPkg.sv */
package mipsPkg;

	// Datapath and address width
	localparam int dataW = 32;
	// Register index width and count
	localparam int regAddrW = 5;
	localparam int regCount = 1 << regAddrW;
	// Opcode and funct field width
	localparam int fieldW = 6;
	// Immediate field width
	localparam int immW = 16;
	// FSM state and ALU control widths
	localparam int stateW = 4;
	localparam int aluCtrlW = 4;

	// Supported opcodes
	typedef enum logic [fieldW-1:0] {
		opRType = 6'd0,
		opJ = 6'd2,
		opBeq = 6'd4,
		opBne = 6'd5,
		opAddi = 6'd8,
		opSlti = 6'd10,
		opAndi = 6'd12,
		opOri = 6'd13,
		opLw = 6'd35,
		opSw = 6'd43
	} opcodeT;

	// R-type funct codes
	typedef enum logic [fieldW-1:0] {
		fnAdd = 6'd32,
		fnSub = 6'd34,
		fnAnd = 6'd36,
		fnOr = 6'd37,
		fnSlt = 6'd42
	} functT;

	// Multicycle FSM states
	typedef enum logic [stateW-1:0] {
		sFetch,
		sDecode,
		sMemAdr,
		sMemRead,
		sMemWriteback,
		sMemWrite,
		sExecute,
		sAluWriteback,
		sBranch,
		sItypeExecute,
		sItypeWriteback,
		sJump
	} stateT;

	// ALU operation class from the FSM
	typedef enum logic [1:0] {
		aluOpAdd,
		aluOpSub,
		aluOpFunct,
		aluOpItype
	} aluOpT;

	// ALU control, classic encoding
	typedef enum logic [aluCtrlW-1:0] {
		aluAnd = 4'd0,
		aluOr = 4'd1,
		aluAdd = 4'd2,
		aluSub = 4'd6,
		aluSlt = 4'd7,
		aluNor = 4'd12
	} aluCtrlT;

endpackage

/* design/regFile.sv */
`timescale 1ns/1ps

module regFile (
	input logic cclk,
	input logic we,
	input logic [mipsPkg::regAddrW-1:0] ra1,
	input logic [mipsPkg::regAddrW-1:0] ra2,
	input logic [mipsPkg::regAddrW-1:0] wa,
	input logic [mipsPkg::dataW-1:0] wd,
	output logic [mipsPkg::dataW-1:0] rd1,
	output logic [mipsPkg::dataW-1:0] rd2
);
	import mipsPkg::*;

	logic [dataW-1:0] regs [regCount];

	// Writes to r0 are dropped
	always_ff @(posedge cclk) begin
		if (we && wa != '0) begin
			regs[wa] <= wd;
		end
	end

	// Asynchronous reads, r0 hardwired to zero
	assign rd1 = (ra1 == '0) ? '0 : regs[ra1];
	assign rd2 = (ra2 == '0) ? '0 : regs[ra2];

endmodule

/* run.sh */
#!/bin/bash
verilator --binary --assert -j 0 --top-module mipsCoreTb -f verilog.f \
	&& ./obj_dir/VmipsCoreTb | tee /dev/stderr | grep "PASS: all tests" > /dev/null \
	|| { echo "Simulation failed"; exit 1; }

/* sim/mipsCoreTb.sv */
`timescale 1ns/1ps

module mipsCoreTb;
	import mipsPkg::*;

	// Program length in words and longest ack delay
	localparam int progLen = 29;
	localparam int maxWait = 4;

	logic cclk, rstb, cyc, stb, we, ack;
	logic [dataW-1:0] adr, datW, datR;
	// Ack delay for the next bus cycle
	logic [2:0] waitCycles;
	// Instruction set model state
	logic [dataW-1:0] refRegs [regCount];
	logic [dataW-1:0] refMem [256];
	logic [dataW-1:0] refPc;
	logic [31:0] lfsr = 32'ha335_5cd9;
	// Expected and held bus values
	int errors = 0, checks = 0, memKind;
	logic expWe = 1'b0, expFetch = 1'b1, waiting = 1'b0, ackSeen = 1'b0, heldWe;
	logic [dataW-1:0] expAdr = '0, lastFetch = '1, nextPc, expDat, mAdr;
	logic [dataW-1:0] heldAdr, heldDat;
	// Operations covered by the store sequences
	functT rOps [5] = '{fnAdd, fnSub, fnAnd, fnOr, fnSlt};
	opcodeT iOps [4] = '{opAddi, opSlti, opAndi, opOri};
	int iImms [4] = '{-5, -1, 'h8F0F, 'h8000};
	// Source registers, slti reads r0 where a zero-extended immediate flips the result
	logic [regAddrW-1:0] iSrcs [4] = '{5'd1, 5'd0, 5'd1, 5'd1};

	mipsCore i_mipsCore (.*);
	wbMemModel i_wbMemModel (.*);

	// Galois LFSR stepped once per bit taken
	function automatic logic [31:0] randBits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
		end
		return v;
	endfunction

	// Runs the instruction at refPc and returns the next fetch address
	function automatic logic [dataW-1:0] refStep(output int kind,
			output logic [dataW-1:0] ma, output logic [dataW-1:0] md);
		logic [dataW-1:0] ins, rs, rt, sImm, zImm, rdVal;
		ins = refMem[refPc[9:2]];
		rs = refRegs[ins[25:21]];
		rt = refRegs[ins[20:16]];
		sImm = {{16{ins[15]}}, ins[15:0]};
		zImm = {16'h0, ins[15:0]};
		kind = 0;
		ma = rs + sImm;
		md = rt;
		refPc = refPc + 4;
		case (ins[5:0])
			fnAdd: rdVal = rs + rt;
			fnSub: rdVal = rs - rt;
			fnAnd: rdVal = rs & rt;
			fnOr: rdVal = rs | rt;
			default: rdVal = {31'b0, $signed(rs) < $signed(rt)};
		endcase
		case (ins[31:26])
			opRType: refRegs[ins[15:11]] = rdVal;
			opLw: begin
				kind = 1;
				refRegs[ins[20:16]] = refMem[ma[9:2]];
			end
			opSw: begin
				kind = 2;
				refMem[ma[9:2]] = rt;
			end
			opBeq: refPc = (rs == rt) ? refPc + (sImm << 2) : refPc;
			opBne: refPc = (rs != rt) ? refPc + (sImm << 2) : refPc;
			opAddi: refRegs[ins[20:16]] = rs + sImm;
			opSlti: refRegs[ins[20:16]] = {31'b0, $signed(rs) < $signed(sImm)};
			opAndi: refRegs[ins[20:16]] = rs & zImm;
			opOri: refRegs[ins[20:16]] = rs | zImm;
			opJ: refPc = {refPc[31:28], ins[25:0], 2'b00};
			default: kind = 0;
		endcase
		refRegs[0] = '0;
		return refPc;
	endfunction

	// Wrong value seen on the bus
	task automatic reportMismatch(input string msg);
		errors++;
		$display("MISMATCH %0t: %s", $time, msg);
	endtask

	task automatic reportFailure(input string msg);
		errors++;
		$display("Error at %0t: %s", $time, msg);
	endtask

	initial begin
		cclk = 1'b0;
		forever #2 cclk = ~cclk;
	end

	initial begin
		rstb <= 1'b0;
		waitCycles <= 3'd1;
		refPc = '0;
		refRegs = '{default: '0};
		for (int i = 0; i < 256; i++) begin
			refMem[i] = randBits(32);
		end
		// Operands from the LFSR words at 0x200 and 0x204
		refMem[0] = {opLw, 5'd0, 5'd1, 16'h0200};
		refMem[1] = {opLw, 5'd0, 5'd2, 16'h0204};
		// R-type results stored from 0x240
		for (int k = 0; k < 5; k++) begin
			refMem[2 + 2*k] = {opRType, 5'd1, 5'd2, 5'(3 + k), 5'd0, rOps[k]};
			refMem[3 + 2*k] = {opSw, 5'd0, 5'(3 + k), 16'(32'h240 + 4*k)};
		end
		// Negative immediates for addi and slti, top bit set for andi and ori
		for (int k = 0; k < 4; k++) begin
			refMem[12 + 2*k] = {iOps[k], iSrcs[k], 5'(8 + k), 16'(iImms[k])};
			refMem[13 + 2*k] = {opSw, 5'd0, 5'(8 + k), 16'(32'h254 + 4*k)};
		end
		// Taken beq skips a store
		refMem[20] = {opBeq, 5'd1, 5'd1, 16'd1};
		refMem[21] = {opSw, 5'd0, 5'd1, 16'h0280};
		refMem[22] = {opBne, 5'd1, 5'd1, 16'd5};
		refMem[23] = {opBne, 5'd1, 5'd2, 16'd1};
		refMem[24] = {opSw, 5'd0, 5'd2, 16'h0284};
		refMem[25] = {opBeq, 5'd1, 5'd2, 16'd1};
		refMem[26] = {opJ, 26'd28};
		refMem[27] = {opSw, 5'd0, 5'd1, 16'h0288};
		// Jump to itself ends the program
		refMem[28] = {opJ, 26'd28};
		for (int i = 0; i < 256; i++) begin
			i_wbMemModel.mem[i] <= refMem[i];
		end
		repeat (2) @(posedge cclk);
		rstb <= 1'b1;
	end

	// Compares every bus cycle with the model
	always @(posedge cclk) begin
		if (rstb) begin
			assert (cyc == stb && !(ackSeen && stb))
				else reportFailure("cyc and stb disagree or stb stayed high after ack");
			// Address, we and store data hold while stb waits
			assert (!(stb && waiting) ||
					(adr == heldAdr && we == heldWe && (!we || datW == heldDat)))
				else reportMismatch($sformatf("bus moved in wait, adr %h held %h", adr, heldAdr));
			waiting <= stb && !ack;
			ackSeen <= ack;
			heldAdr <= adr;
			heldWe <= we;
			heldDat <= datW;
		end
		if (rstb && ack) begin
			checks++;
			assert (adr == expAdr && we == expWe)
				else reportMismatch($sformatf("adr %h we %b, expected adr %h we %b",
					adr, we, expAdr, expWe));
			assert (!we || datW == expDat)
				else reportMismatch($sformatf("store data %h, expected %h", datW, expDat));
			// Ack delay of 1 to 4 cycles
			waitCycles <= 3'(randBits(2)) + 3'd1;
			if (expFetch && expAdr == lastFetch) begin
				$display("Bus cycles checked %0d, errors %0d", checks, errors);
				if (errors == 0) begin
					$display("PASS: all tests");
				end else begin
					$display("FAIL: see errors above");
				end
				$finish;
			end else if (expFetch) begin
				lastFetch = expAdr;
				nextPc = refStep(memKind, mAdr, expDat);
				expAdr = (memKind == 0) ? nextPc : mAdr;
				expWe = (memKind == 2);
				expFetch = (memKind == 0);
			end else begin
				expAdr = nextPc;
				expWe = 1'b0;
				expFetch = 1'b1;
			end
		end
	end

	// Six cycles per wait on each word, 4 ns clock
	initial begin
		#(progLen * maxWait * 6 * 4);
		reportFailure("timeout, the program never reached its final jump");
		$display("Bus cycles checked %0d, errors %0d", checks, errors);
		$display("FAIL: see errors above");
		$finish;
	end

endmodule

/* sim/wbMemModel.sv */
`timescale 1ns/1ps

module wbMemModel (
	input logic cclk,
	input logic cyc,
	input logic stb,
	input logic we,
	input logic [mipsPkg::dataW-1:0] adr,
	input logic [mipsPkg::dataW-1:0] datW,
	// Cycles from strobe to ack
	input logic [2:0] waitCycles,
	output logic [mipsPkg::dataW-1:0] datR,
	output logic ack
);
	import mipsPkg::*;

	// Unified memory, loaded by the testbench
	logic [dataW-1:0] mem [256];
	// Cycles the current strobe has been high
	logic [2:0] count;

	initial begin
		ack <= 1'b0;
		datR <= '0;
		count <= 3'd1;
	end

	always @(posedge cclk) begin
		if (!(cyc && stb) || ack) begin
			// Idle or the ack cycle itself
			ack <= 1'b0;
			count <= 3'd1;
		end else if (count >= waitCycles) begin
			ack <= 1'b1;
			datR <= mem[adr[9:2]];
			if (we) begin
				mem[adr[9:2]] <= datW;
			end
		end else begin
			count <= count + 3'd1;
		end
	end

endmodule

/* verilog.f */
design/mipsPkg.sv
design/ctrlIf.sv
design/aluDecoder.sv
design/controlUnit.sv
design/alu.sv
design/regFile.sv
design/datapath.sv
design/mipsCore.sv
sim/wbMemModel.sv
sim/mipsCoreTb.sv
